// File: include/sram_macros.svh
`ifndef SRAM_MACROS_SVH
`define SRAM_MACROS_SVH

// burst buffer depth, power of two
`define FIFO_DEPTH 16

`define ADDR_BYTES 2 // 23LC512 takes a 16 bit address
`define DUMMY_BYTES 1 // read bytes dropped before valid data

// command codes, msb first on the wire
`define CMD_QUAD 8'h38 // enter quad io, sent single lane
`define CMD_READ 8'h03 // sequential read
`define CMD_WRITE 8'h02 // sequential write

`endif

// File: logic/byte_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "sram_macros.svh"

module byte_fifo #(
	parameter int DEPTH = `FIFO_DEPTH
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input logic pop,
	input logic clear, // drop everything
	input sram_pkg::byte_t din,
	output sram_pkg::byte_t dout, // head byte, valid while !empty
	output logic full,
	output logic empty
);
	import sram_pkg::*;

	localparam int AW = $clog2(DEPTH);

	byte_t mem [DEPTH];
	logic [AW:0] wptr; // extra msb tells full from empty
	logic [AW:0] rptr;
	logic do_push;
	logic do_pop;

	assign empty = (wptr == rptr);
	assign full = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);
	assign do_push = push && !full; // push while full is dropped
	assign do_pop = pop && !empty;
	assign dout = mem[rptr[AW-1:0]]; // first word falls through

	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (do_push)
				wptr <= wptr + 1'b1;
			if (do_pop)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wptr[AW-1:0]] <= din;
	end

endmodule

`default_nettype wire

// File: logic/sck_timer.sv
`timescale 1ns/10ps
`default_nettype none

module sck_timer (
	input logic clk,
	input logic rst_n,
	input logic [15:0] bauddiv, // clocks per quarter sck period, minus one
	input logic run,
	output logic tick, // one clock pulse at the end of each phase
	output logic [1:0] phase // phase that is ending when tick is high
);
	logic [15:0] cnt; // clocks left in this phase

	assign tick = run && (cnt == 16'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= 16'd0;
			phase <= 2'd0;
		end else if (!run) begin
			cnt <= bauddiv; // reload so the first phase is full length
			phase <= 2'd0; // every byte starts at phase 0
		end else if (tick) begin
			cnt <= bauddiv;
			phase <= phase + 2'd1; // wraps 3 -> 0
		end else begin
			cnt <= cnt - 16'd1;
		end
	end

endmodule

`default_nettype wire

// File: logic/shift_if.sv
`timescale 1ns/10ps
`default_nettype none

interface shift_if;
	import sram_pkg::*;

	logic req; // byte request, sequencer side
	logic ack; // byte done, rx valid while high
	lane_mode_t mode; // single or quad for this byte
	logic tx_dir; // 1 drives lanes, 0 listens (quad only)
	shift_word_u tx; // outgoing byte
	shift_word_u rx; // incoming byte
	logic active; // byte in progress, runs the timer

	modport seq (
		output req,
		output mode,
		output tx_dir,
		output tx,
		input ack
	);

	modport shf (
		input req,
		input mode,
		input tx_dir,
		input tx,
		output ack,
		output rx,
		output active
	);

endinterface

`default_nettype wire

// File: logic/spi_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module spi_shifter (
	input logic clk,
	input logic rst_n,
	input logic tick,
	input logic [1:0] phase,
	shift_if.shf sif,
	output logic sck,
	output logic [3:0] sio_out,
	output logic [3:0] sio_oe,
	input logic [3:0] sio_in
);
	import sram_pkg::*;

	shift_word_u sh_reg; // tx bits leave the top, rx bits enter the bottom
	lane_mode_t mode_r; // mode latched for this byte
	logic [3:0] cnt; // bits or nibbles still to go
	logic busy;
	logic load;
	logic last;

	assign load = !busy && sif.req && !sif.ack; // new byte from the sequencer
	assign last = busy && tick && (phase == 2'd3) && (cnt == 4'd1);
	assign sif.active = busy;
	assign sif.rx = sh_reg; // holds the full rx byte once ack is up

	// control side, handshake and pin timing
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			sif.ack <= 1'b0;
			mode_r <= LANE_SINGLE;
			cnt <= 4'd0;
			sck <= 1'b0;
			sio_out <= 4'b0000;
			sio_oe <= 4'b0000;
		end else if (load) begin
			busy <= 1'b1;
			mode_r <= sif.mode;
			cnt <= (sif.mode == LANE_QUAD) ? 4'd2 : 4'd8;
			if (sif.mode == LANE_SINGLE)
				sio_oe <= 4'b0001; // mosi only, miso on sio1
			else
				sio_oe <= sif.tx_dir ? 4'b1111 : 4'b0000;
		end else if (!busy) begin
			if (!sif.req && sif.ack) begin
				sif.ack <= 1'b0; // four phase return to zero
				sio_oe <= 4'b0000; // release lanes between bytes
			end
		end else if (tick) begin
			if (phase == 2'd0) begin
				// lanes valid through phase 1, ahead of the rising edge
				if (mode_r == LANE_QUAD)
					sio_out <= sh_reg.nib[1];
				else
					sio_out <= {3'b000, sh_reg.bits[7]};
			end
			if (phase == 2'd1)
				sck <= 1'b1; // high for phases 2 and 3
			if (phase == 2'd3) begin
				sck <= 1'b0;
				cnt <= cnt - 4'd1;
				if (last) begin
					busy <= 1'b0; // timer stops and reloads
					sif.ack <= 1'b1;
				end
			end
		end
	end

	// data side, load then shift on each sample
	always_ff @(posedge clk) begin
		if (load) begin
			sh_reg <= sif.tx;
		end else if (busy && tick && phase == 2'd3) begin
			if (mode_r == LANE_QUAD)
				sh_reg.nib <= {sh_reg.nib[0], sio_in}; // sample before sck falls
			else
				sh_reg.bits <= {sh_reg.bits[6:0], sio_in[1]};
		end
	end

endmodule

`default_nettype wire

// File: logic/spi_sram_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "sram_macros.svh"

module spi_sram_ctrl (
	input logic clk,
	input logic rst_n,
	input logic [15:0] bauddiv,
	input sram_pkg::byte_t wr_data,
	input logic wr_valid,
	output logic wr_ready,
	output sram_pkg::byte_t rd_data,
	output logic rd_valid,
	input logic rd_pop,
	input logic cmd_req,
	output logic cmd_ack,
	input logic cmd_write,
	input sram_pkg::addr_t cmd_addr,
	input sram_pkg::len_t cmd_len,
	output logic init_done,
	output logic cs_n,
	output logic sck,
	output logic [3:0] sio_out,
	output logic [3:0] sio_oe,
	input logic [3:0] sio_in
);
	import sram_pkg::*;

	logic tick;
	logic [1:0] phase;
	byte_t tx_head; // tx fifo head into the sequencer
	logic tx_full;
	logic tx_empty;
	logic tx_pop;
	logic rx_push;
	logic rx_full;
	logic rx_empty;
	logic fifo_clear;

	shift_if sif ();

	assign wr_ready = !tx_full;
	assign rd_valid = !rx_empty;

	sck_timer i_sck_timer (
		.clk(clk),
		.rst_n(rst_n),
		.bauddiv(bauddiv),
		.run(sif.active), // timer only runs while a byte is shifting
		.tick(tick),
		.phase(phase)
	);

	byte_fifo #(.DEPTH(`FIFO_DEPTH)) tx_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(wr_valid),
		.pop(tx_pop),
		.clear(1'b0), // user data survives between bursts
		.din(wr_data),
		.dout(tx_head),
		.full(tx_full),
		.empty(tx_empty)
	);

	byte_fifo #(.DEPTH(`FIFO_DEPTH)) rx_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(rx_push),
		.pop(rd_pop),
		.clear(fifo_clear),
		.din(sif.rx.bits),
		.dout(rd_data),
		.full(rx_full),
		.empty(rx_empty)
	);

	spi_shifter i_spi_shifter (
		.clk(clk),
		.rst_n(rst_n),
		.tick(tick),
		.phase(phase),
		.sif(sif),
		.sck(sck),
		.sio_out(sio_out),
		.sio_oe(sio_oe),
		.sio_in(sio_in)
	);

	sram_sequencer i_sram_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.cmd_write(cmd_write),
		.cmd_addr(cmd_addr),
		.cmd_len(cmd_len),
		.tx_data(tx_head),
		.tx_empty(tx_empty),
		.tx_pop(tx_pop),
		.rx_push(rx_push),
		.rx_full(rx_full),
		.fifo_clear(fifo_clear),
		.cs_n(cs_n),
		.init_done(init_done),
		.sif(sif)
	);

endmodule

`default_nettype wire

// File: logic/sram_pkg.sv
`default_nettype none

package sram_pkg;

	typedef logic [7:0] byte_t; // one data byte
	typedef logic [15:0] addr_t; // sram byte address
	typedef logic [4:0] len_t; // burst length, 1 to 16

	typedef enum logic {
		LANE_SINGLE = 1'b0, // sio0 out, sio1 in
		LANE_QUAD = 1'b1 // all four lanes, nibble wide
	} lane_mode_t;

	// the byte on its way through the shifter
	typedef union packed {
		logic [7:0] bits; // single lane view, bit 7 leaves first
		logic [1:0][3:0] nib; // quad view, nib[1] leaves first
	} shift_word_u;

	typedef enum logic [3:0] {
		S_INIT, // send 0x38 after reset
		S_IDLE, // wait for cmd_req
		S_CMD, // command byte
		S_ADDR, // address bytes, high first
		S_DUMMY, // read turnaround bytes
		S_DATA, // payload bytes
		S_HANGUP, // raise cs
		S_ACK // hold cmd_ack until req drops
	} seq_state_t;

endpackage

`default_nettype wire

// File: logic/sram_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "sram_macros.svh"

module sram_sequencer (
	input logic clk,
	input logic rst_n,
	input logic cmd_req,
	output logic cmd_ack,
	input logic cmd_write, // 1 write burst, 0 read burst
	input sram_pkg::addr_t cmd_addr,
	input sram_pkg::len_t cmd_len,
	input sram_pkg::byte_t tx_data, // head of the tx fifo
	input logic tx_empty,
	output logic tx_pop,
	output logic rx_push,
	input logic rx_full,
	output logic fifo_clear, // empties the rx fifo before a read
	output logic cs_n,
	output logic init_done,
	shift_if.seq sif
);
	import sram_pkg::*;

	localparam int AW = $bits(addr_t);

	seq_state_t state;
	logic wr_r; // burst direction
	addr_t addr_r; // shifts left one byte per address byte sent
	len_t len_r;
	len_t data_cnt; // payload bytes finished
	logic [1:0] idx; // address or dummy bytes left, minus one
	logic hs_idle; // nothing in flight, shifter ack back low
	logic byte_done;
	logic data_left;

	assign hs_idle = !sif.req && !sif.ack;
	assign byte_done = sif.req && sif.ack;
	assign data_left = (data_cnt != len_r);

	// pop comes with the request, fifo head goes straight into tx
	assign tx_pop = (state == S_DATA) && wr_r && hs_idle && data_left && !tx_empty;
	// rx byte is stable while ack is high
	assign rx_push = (state == S_DATA) && !wr_r && byte_done;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_INIT;
			sif.req <= 1'b0;
			cs_n <= 1'b1;
			init_done <= 1'b0;
			cmd_ack <= 1'b0;
			fifo_clear <= 1'b0;
			data_cnt <= '0;
			idx <= 2'd0;
		end else begin
			fifo_clear <= 1'b0;
			if (byte_done)
				sif.req <= 1'b0; // drop req as soon as ack shows
			case (state)
				S_INIT: begin
					if (hs_idle) begin
						cs_n <= 1'b0;
						sif.req <= 1'b1;
					end else if (byte_done) begin
						state <= S_HANGUP;
					end
				end
				S_IDLE: begin
					if (cmd_req) begin
						cs_n <= 1'b0;
						fifo_clear <= !cmd_write;
						data_cnt <= '0;
						state <= S_CMD;
					end
				end
				S_CMD: begin
					if (hs_idle) begin
						sif.req <= 1'b1;
					end else if (byte_done) begin
						idx <= 2'(`ADDR_BYTES - 1);
						state <= S_ADDR;
					end
				end
				S_ADDR: begin
					if (hs_idle) begin
						sif.req <= 1'b1;
					end else if (byte_done) begin
						if (idx != 2'd0) begin
							idx <= idx - 2'd1;
						end else if (wr_r) begin
							state <= S_DATA; // writes have no turnaround
						end else begin
							idx <= 2'(`DUMMY_BYTES - 1);
							state <= S_DUMMY;
						end
					end
				end
				S_DUMMY: begin
					if (hs_idle) begin
						sif.req <= 1'b1;
					end else if (byte_done) begin
						if (idx != 2'd0)
							idx <= idx - 2'd1;
						else
							state <= S_DATA; // dummy rx byte is dropped
					end
				end
				S_DATA: begin
					if (byte_done) begin
						data_cnt <= data_cnt + 1'b1;
					end else if (hs_idle) begin
						if (!data_left || (wr_r && tx_empty))
							state <= S_HANGUP; // short write when fifo runs dry
						else if (wr_r || !rx_full)
							sif.req <= 1'b1; // full rx fifo stalls here, cs held low
					end
				end
				S_HANGUP: begin
					cs_n <= 1'b1;
					if (!init_done) begin
						init_done <= 1'b1; // quad mode entered, no user ack
						state <= S_IDLE;
					end else begin
						state <= S_ACK;
					end
				end
				S_ACK: begin
					cmd_ack <= 1'b1; // one clock after cs rose
					if (cmd_ack && !cmd_req) begin
						cmd_ack <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// burst parameters and the byte offered to the shifter
	always_ff @(posedge clk) begin
		if (state == S_IDLE && cmd_req) begin
			wr_r <= cmd_write;
			addr_r <= cmd_addr;
			len_r <= cmd_len;
		end else if (state == S_ADDR && byte_done) begin
			addr_r <= addr_r << 8; // next byte to the top
		end
		if (hs_idle) begin
			case (state)
				S_INIT: begin
					sif.tx.bits <= `CMD_QUAD;
					sif.mode <= LANE_SINGLE; // part still in spi mode here
					sif.tx_dir <= 1'b1;
				end
				S_CMD: begin
					sif.tx.bits <= wr_r ? `CMD_WRITE : `CMD_READ;
					sif.mode <= LANE_QUAD;
					sif.tx_dir <= 1'b1;
				end
				S_ADDR: begin
					sif.tx.bits <= addr_r[AW-1 -: 8];
					sif.mode <= LANE_QUAD;
					sif.tx_dir <= 1'b1;
				end
				S_DUMMY: begin
					sif.tx.bits <= 8'h00;
					sif.mode <= LANE_QUAD;
					sif.tx_dir <= 1'b0; // turnaround, sram takes the lanes
				end
				S_DATA: begin
					sif.tx.bits <= wr_r ? tx_data : 8'h00;
					sif.mode <= LANE_QUAD;
					sif.tx_dir <= wr_r;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module tb_spi_sram || exit 1
sim_out=$(./obj_dir/Vtb_spi_sram)
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: verif/sram_model.sv
`timescale 1ns/10ps
`default_nettype none
`include "sram_macros.svh"

module sram_model (
	input logic cs_n,
	input logic sck,
	input logic [3:0] sio_out, // controller lanes
	input logic [3:0] sio_oe,
	output logic [3:0] sio_in, // resolved lanes back to the controller
	output logic quad_on, // 0x38 seen in spi mode
	output logic proto_err // transfer the 23LC512 would reject
);
	import sram_pkg::*;

	byte_t mem [65536]; // 64 KiB array
	byte_t sh; // shift in, msb first
	byte_t cmd;
	addr_t ptr; // current byte address, wraps at 64 KiB
	int ncnt; // bits or nibbles clocked in since cs fell
	logic [3:0] drv; // nibble the sram puts out
	logic drv_en;

	// lanes the controller leaves undriven carry the sram, else a pull-up
	assign sio_in = (sio_oe & sio_out) | (~sio_oe & (drv_en ? drv : 4'hf));

	initial begin
		quad_on = 1'b0; // part powers up in spi mode
		proto_err = 1'b0;
		ncnt = 0;
		drv_en = 1'b0;
		drv = 4'h0;
		sh = 8'h00;
		cmd = 8'h00;
		ptr = 16'h0000;
		for (int a = 0; a < 65536; a++)
			mem[a[15:0]] = a[7:0] ^ a[15:8] ^ 8'h5a; // power-up fill, whole address
	end

	always @(posedge sck or negedge sck or posedge cs_n) begin
		if (cs_n) begin
			ncnt = 0; // burst over, sram lets go of the lanes
			drv_en = 1'b0;
		end else if (sck && !quad_on) begin
			sh = {sh[6:0], sio_out[0]}; // spi mode, si on lane 0
			ncnt = ncnt + 1;
			if (ncnt == 8) begin
				if (sh == `CMD_QUAD)
					quad_on = 1'b1;
				else
					proto_err = 1'b1;
			end
		end else if (sck) begin
			sh = {sh[3:0], sio_out}; // quad mode, high nibble first
			if (ncnt == 1) begin
				cmd = sh;
				if (cmd != `CMD_READ && cmd != `CMD_WRITE)
					proto_err = 1'b1; // only sequential read and write here
			end else if (ncnt == 3 || ncnt == 5) begin
				ptr = {ptr[7:0], sh}; // address, high byte first
			end else if (ncnt >= 7 && ncnt % 2 == 1 && cmd == `CMD_WRITE) begin
				mem[ptr] = sh;
				ptr = ptr + 16'd1;
			end
			ncnt = ncnt + 1;
		end else if (quad_on && cmd == `CMD_READ && ncnt >= 8) begin
			// falling edge after the dummy byte, next nibble out
			drv_en = 1'b1;
			if (ncnt % 2 == 0) begin
				drv = mem[ptr][7:4];
			end else begin
				drv = mem[ptr][3:0];
				ptr = ptr + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_spi_sram.sv
`timescale 1ns/10ps
`default_nettype none
`include "sram_macros.svh"

module tb_spi_sram;
	import sram_pkg::*;

	localparam int BAUDDIV = 1;
	localparam int CLK_NS = 20;
	localparam int N_BURSTS = 48; // upper bound on bursts in all tests below
	localparam int BURST_BYTES = 1 + `ADDR_BYTES + `DUMMY_BYTES + `FIFO_DEPTH; // longest burst
	localparam longint WATCHDOG_NS =
		longint'(1 + N_BURSTS * BURST_BYTES) * 8 * 4 * (BAUDDIV + 1) * CLK_NS * 4;

	logic clk = 1'b0;
	logic rst_n;
	logic [15:0] bauddiv;
	byte_t wr_data;
	logic wr_valid;
	logic wr_ready;
	byte_t rd_data;
	logic rd_valid;
	logic rd_pop;
	logic cmd_req;
	logic cmd_ack;
	logic cmd_write;
	addr_t cmd_addr;
	len_t cmd_len;
	logic init_done;
	logic cs_n;
	logic sck;
	logic [3:0] sio_out;
	logic [3:0] sio_oe;
	logic [3:0] sio_in;
	logic quad_on;
	logic proto_err;

	byte_t shadow [65536]; // what the sram should hold
	byte_t wr_q[$]; // bytes pushed for the next write burst
	byte_t exp_q[$]; // bytes the next pops must return
	string test_name = "";
	int err_cnt = 0;
	int chk_cnt = 0;
	int test_cnt = 0;
	int test_fail = 0;
	int test_err0 = 0; // err_cnt when the test began
	logic sck_mon = 1'b0; // sck and cs_n monitors armed
	time sck_rise_t = 0;
	int sck_highs = 0;
	int cs_rises = 0;

	always #(CLK_NS / 2) clk = ~clk;

	spi_sram_ctrl i_spi_sram_ctrl (
		.clk(clk), .rst_n(rst_n), .bauddiv(bauddiv),
		.wr_data(wr_data), .wr_valid(wr_valid), .wr_ready(wr_ready),
		.rd_data(rd_data), .rd_valid(rd_valid), .rd_pop(rd_pop),
		.cmd_req(cmd_req), .cmd_ack(cmd_ack), .cmd_write(cmd_write),
		.cmd_addr(cmd_addr), .cmd_len(cmd_len), .init_done(init_done),
		.cs_n(cs_n), .sck(sck), .sio_out(sio_out), .sio_oe(sio_oe), .sio_in(sio_in)
	);

	sram_model i_sram_model (
		.cs_n(cs_n), .sck(sck), .sio_out(sio_out), .sio_oe(sio_oe),
		.sio_in(sio_in), .quad_on(quad_on), .proto_err(proto_err)
	);

	function automatic byte_t fill_byte(input addr_t a);
		return a[7:0] ^ a[15:8] ^ 8'h5a; // sram power-up contents
	endfunction

	function automatic byte_t ref_read(input addr_t a);
		return shadow[a];
	endfunction

	task automatic check_byte(input string what, input byte_t exp, input byte_t act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("Fail %s %s: expected 8'h%02h, actual 8'h%02h", test_name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		chk_cnt++;
		if (act != exp) begin
			err_cnt++;
			$display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		err_cnt++;
		$display("Error in %s: %s", test_name, msg);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = err_cnt;
	endtask

	task automatic finish_test();
		test_cnt++;
		if (err_cnt == test_err0) begin
			$display("test %s: passed", test_name);
		end else begin
			test_fail++;
			$display("test %s: %0d errors", test_name, err_cnt - test_err0);
		end
	endtask

	task automatic push_byte(input byte_t b);
		while (!wr_ready) begin
			@(posedge clk);
			#2;
		end
		wr_data = b;
		wr_valid = 1'b1;
		wr_q.push_back(b); // goes to shadow once the burst is done
		@(posedge clk);
		#2;
		wr_valid = 1'b0;
	endtask

	// one burst through the req/ack handshake with ack held for hold clocks
	task automatic run_burst(input logic wr, input addr_t a, input len_t n, input int hold);
		if (!wr) begin
			for (int i = 0; i < int'(n); i++)
				exp_q.push_back(ref_read(addr_t'(a + addr_t'(i))));
		end
		cmd_write = wr;
		cmd_addr = a;
		cmd_len = n;
		cmd_req = 1'b1;
		while (!cmd_ack) begin
			@(posedge clk);
			#2;
		end
		check_flag("cs_n at cmd_ack", 1'b1, cs_n); // ack only after cs rose
		repeat (hold) begin
			@(posedge clk);
			#2;
			check_flag("cmd_ack while req held", 1'b1, cmd_ack);
		end
		cmd_req = 1'b0;
		@(posedge clk);
		#2;
		check_flag("cmd_ack after req fell", 1'b0, cmd_ack);
		if (wr) begin
			for (int i = 0; i < int'(n); i++)
				shadow[addr_t'(a + addr_t'(i))] = wr_q.pop_front();
		end
	endtask

	task automatic pop_bytes(input int n);
		for (int i = 0; i < n; i++) begin
			if (!rd_valid) begin
				report_error("receive FIFO ran empty before all bytes were read");
				break;
			end
			rd_pop = 1'b1; // compare process checks rd_data at negedge
			@(posedge clk);
			#2;
			rd_pop = 1'b0;
		end
		if (exp_q.size() != 0)
			report_error("some expected read bytes never arrived");
		exp_q.delete();
	endtask

	// compare popped bytes against ref_read
	always @(negedge clk) begin
		if (rd_pop && rd_valid) begin
			if (exp_q.size() == 0)
				report_error("read byte popped with nothing expected");
			else
				check_byte("rd_data", exp_q.pop_front(), rd_data);
		end
	end

	always @(posedge sck) begin
		sck_rise_t = $time;
		if (sck_mon)
			check_flag("cs_n at sck rise", 1'b0, cs_n);
	end

	always @(negedge sck) begin
		if (sck_mon) begin
			sck_highs++;
			check_count("sck high clocks", 2 * (BAUDDIV + 1), int'(($time - sck_rise_t) / CLK_NS));
			check_flag("cs_n at sck fall", 1'b0, cs_n);
		end
	end

	always @(posedge cs_n) begin
		if (sck_mon)
			cs_rises++;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		addr_t wa;
		addr_t ra;
		len_t wn;
		len_t rn;
		rst_n = 1'b0;
		bauddiv = 16'(BAUDDIV);
		wr_data = 8'h00;
		wr_valid = 1'b0;
		rd_pop = 1'b0;
		cmd_req = 1'b0;
		cmd_write = 1'b0;
		cmd_addr = 16'h0000;
		cmd_len = 5'd0;
		void'($urandom(32'he990_97f2));
		for (int a = 0; a < 65536; a++)
			shadow[a[15:0]] = fill_byte(a[15:0]);

		start_test("reset and quad entry");
		repeat (8) @(posedge clk);
		#2;
		check_flag("cs_n in reset", 1'b1, cs_n);
		check_flag("sck in reset", 1'b0, sck);
		check_flag("sio_oe in reset", 1'b0, |sio_oe);
		check_flag("cmd_ack in reset", 1'b0, cmd_ack);
		check_flag("rd_valid in reset", 1'b0, rd_valid);
		check_flag("init_done in reset", 1'b0, init_done);
		rst_n = 1'b1;
		while (!init_done) begin
			@(posedge clk);
			#2;
		end
		check_flag("0x38 seen in spi mode", 1'b1, quad_on);
		finish_test();

		start_test("write then read 4 bytes");
		push_byte(8'ha5);
		push_byte(8'h3c);
		push_byte(8'h96);
		push_byte(8'h0f);
		run_burst(1'b1, 16'h0100, 5'd4, 0);
		run_burst(1'b0, 16'h0100, 5'd4, 0);
		pop_bytes(4);
		finish_test();

		start_test("four phase handshake");
		run_burst(1'b0, 16'h0100, 5'd2, 6);
		pop_bytes(2);
		finish_test();

		start_test("sck high time and cs_n");
		for (int i = 0; i < 8; i++)
			push_byte(byte_t'($urandom));
		sck_mon = 1'b1;
		run_burst(1'b1, 16'h0400, 5'd8, 0);
		sck_mon = 1'b0;
		check_count("sck pulses", (1 + `ADDR_BYTES + 8) * 2, sck_highs); // 2 nibbles a byte
		check_count("cs_n rises", 1, cs_rises);
		finish_test();

		start_test("random bursts");
		for (int k = 0; k < 20; k++) begin
			wa = addr_t'($urandom);
			wn = len_t'($urandom_range(16, 1));
			for (int i = 0; i < int'(wn); i++)
				push_byte(byte_t'($urandom));
			run_burst(1'b1, wa, wn, 0);
			ra = (k % 2 == 0) ? wa : addr_t'($urandom); // half read back what was written
			rn = len_t'($urandom_range(16, 1));
			run_burst(1'b0, ra, rn, 0);
			pop_bytes(int'(rn));
		end
		finish_test();

		start_test("full receive FIFO");
		for (int i = 0; i < 16; i++)
			push_byte(byte_t'($urandom));
		check_flag("wr_ready with full tx FIFO", 1'b0, wr_ready);
		run_burst(1'b1, 16'hfff8, 5'd16, 0); // crosses the top of the array
		check_flag("wr_ready after write burst", 1'b1, wr_ready);
		run_burst(1'b0, 16'hfff8, 5'd16, 0);
		repeat (10) @(posedge clk);
		#2;
		check_flag("rd_valid with full FIFO", 1'b1, rd_valid);
		pop_bytes(16);
		check_flag("rd_valid after draining", 1'b0, rd_valid);
		check_flag("sram model protocol error", 1'b0, proto_err);
		finish_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			test_cnt, test_fail, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
logic/sram_pkg.sv
logic/shift_if.sv
logic/sck_timer.sv
logic/byte_fifo.sv
logic/spi_shifter.sv
logic/sram_sequencer.sv
logic/spi_sram_ctrl.sv
verif/sram_model.sv
verif/tb_spi_sram.sv
